/* logic/byte_lane_bridge.sv */
`default_nettype none

module byte_lane_bridge #(
  parameter int addr_bits = 17
) (
  input  wire                            clearing,
  input  wire snes_load_pkg::fill_addr_t fill_addr,
  input  wire snes_load_pkg::byte_t      fill_byte,
  input  wire [addr_bits-1:0]            ram_addr,
  input  wire snes_load_pkg::byte_t      ram_d,
  input  wire                            ram_ce_n,
  input  wire                            ram_oe_n,
  input  wire                            ram_we_n,
  input  wire snes_load_pkg::word_t      mem_dout,
  output snes_load_pkg::byte_t           ram_q,
  output logic [addr_bits-2:0]           mem_addr,
  output snes_load_pkg::word_t           mem_din,
  output logic                           mem_we,
  output logic                           mem_be_hi,
  output logic                           mem_be_lo,
  output logic                           mem_re
);

  logic [addr_bits-1:0] byte_addr;
  logic                 lane_hi;
  snes_load_pkg::byte_t wr_byte;

  // clear sequencer owns the port while clearing
  assign byte_addr = clearing ? fill_addr[addr_bits-1:0] : ram_addr;
  assign wr_byte   = clearing ? fill_byte : ram_d;

  // odd byte lives in the high lane
  assign lane_hi = byte_addr[0];

  // word address drops the lane bit
  assign mem_addr = byte_addr[addr_bits-1:1];

  // write byte in its lane, zero in the other
  assign mem_din = lane_hi ? {wr_byte, 8'h00} : {8'h00, wr_byte};

  // lane enables follow the address alone
  assign mem_be_hi = lane_hi;
  assign mem_be_lo = ~lane_hi;

  // clear writes every cycle and never reads
  assign mem_we = clearing | (~ram_ce_n & ~ram_we_n);
  assign mem_re = ~clearing & ~ram_ce_n & ~ram_oe_n;

  // read data same cycle, byte picked by lane
  assign ram_q = lane_hi ? mem_dout[15:8] : mem_dout[7:0];

endmodule

`default_nettype wire

/* logic/fill_counter.sv */
`default_nettype none

module fill_counter (
  input  wire                      clk_sys,
  input  wire                      reset,
  input  wire                      clearing,
  input  wire                      div_tick,
  output snes_load_pkg::fill_addr_t fill_addr,
  output logic                     fill_last
);

  // all ones marks the final byte of work ram
  assign fill_last = &fill_addr;

  // clear address, parked at zero outside a clear
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      fill_addr <= '0;
    end else if (!clearing) begin
      fill_addr <= '0;
    end else if (div_tick) begin
      // one byte per divider period, slow enough for the psram
      fill_addr <= fill_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/fill_pattern.sv */
`default_nettype none

module fill_pattern (
  input  wire snes_load_pkg::fill_addr_t fill_addr,
  input  wire snes_load_pkg::fill_mode_t fill_mode,
  output snes_load_pkg::byte_t           fill_byte
);

  always_comb begin
    case (fill_mode)
      // checker of 66/99 from address bits 8 and 2
      2'd0: begin
        fill_byte = (fill_addr[8] ^ fill_addr[2]) ? snes_load_pkg::fill_byte_a
                                                  : snes_load_pkg::fill_byte_b;
      end
      // ff/00 from address bits 9 and 0
      2'd1: begin
        fill_byte = (fill_addr[9] ^ fill_addr[0]) ? snes_load_pkg::fill_byte_ones
                                                  : snes_load_pkg::fill_byte_zero;
      end
      // flat 55
      2'd2: begin
        fill_byte = snes_load_pkg::fill_byte_c;
      end
      // flat ff
      default: begin
        fill_byte = snes_load_pkg::fill_byte_ones;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/load_control.sv */
`default_nettype none

module load_control (
  input  wire  clk_sys,
  input  wire  reset,
  input  wire  cart_download,
  input  wire  reset_request,
  input  wire  fill_last,
  output logic clearing,
  output logic div_tick,
  output logic load_masks,
  output logic core_reset_n,
  output logic refresh
);

  // wide enough to hold the settle load value
  localparam int cnt_bits = $clog2(snes_load_pkg::settle_cycles + 1);

  snes_load_pkg::load_state_t state;
  logic                       prev_download;
  logic                       dl_rise;
  logic                       dl_fall;
  logic [cnt_bits-1:0]        settle_cnt;
  logic [1:0]                 div;
  logic                       hold;

  // download edges against last sampled level
  assign dl_rise = cart_download & ~prev_download;
  assign dl_fall = ~cart_download & prev_download;

  // anything that keeps the core parked
  assign hold = reset_request | cart_download | clearing | (settle_cnt != '0);

  // fill pacing, one tick per divider period
  assign div_tick = (div == 2'd0);

  // masks latch on the last settle count
  assign load_masks = (state == snes_load_pkg::ld_settle) &&
                      (settle_cnt == cnt_bits'(1));

  // sequencing FSM and settle countdown
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state         <= snes_load_pkg::ld_run;
      prev_download <= 1'b0;
      settle_cnt    <= '0;
    end else begin
      prev_download <= cart_download;
      // free countdown, overridden below
      if (settle_cnt != '0) begin
        settle_cnt <= settle_cnt - 1'b1;
      end
      case (state)
        snes_load_pkg::ld_run: begin
          if (dl_rise) begin
            state <= snes_load_pkg::ld_download;
          end
        end
        snes_load_pkg::ld_download: begin
          // download done, give the size codes time to settle
          if (dl_fall) begin
            state      <= snes_load_pkg::ld_settle;
            settle_cnt <= cnt_bits'(snes_load_pkg::settle_cycles);
          end
        end
        snes_load_pkg::ld_settle: begin
          // new download restarts the whole sequence
          if (dl_rise) begin
            state      <= snes_load_pkg::ld_download;
            settle_cnt <= '0;
          end else if (settle_cnt == cnt_bits'(1)) begin
            state <= snes_load_pkg::ld_run;
          end
        end
        default: begin
          state <= snes_load_pkg::ld_run;
        end
      endcase
    end
  end

  // ram clear flag
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clearing <= 1'b0;
    end else if (dl_rise) begin
      clearing <= 1'b1;
    end else if (fill_last) begin
      // last address reached
      clearing <= 1'b0;
    end
  end

  // 4-cycle divider, refresh slot and core reset release
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      div          <= 2'd0;
      refresh      <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      div     <= div + 2'd1;
      refresh <= (div == 2'd0);
      // reset only changes on one phase of the divider
      if (div == snes_load_pkg::div_release_phase) begin
        core_reset_n <= ~hold;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mask_builder.sv */
`default_nettype none

module mask_builder (
  input  wire                       clk_sys,
  input  wire                       reset,
  input  wire                       load_masks,
  input  wire snes_load_pkg::size_code_t rom_size_code,
  input  wire snes_load_pkg::size_code_t ram_size_code,
  output snes_load_pkg::mem_mask_t  rom_mask,
  output snes_load_pkg::mem_mask_t  ram_mask,
  output snes_load_pkg::size_code_t sram_size
);

  snes_load_pkg::mem_mask_t rom_mask_next;
  snes_load_pkg::mem_mask_t ram_mask_next;

  // size is 1 KiB << code, mask is size - 1
  assign rom_mask_next = (snes_load_pkg::mem_mask_t'(1024) << rom_size_code) -
                         snes_load_pkg::mem_mask_t'(1);

  // code 0 means no cart ram at all
  assign ram_mask_next = (ram_size_code != '0) ?
                         (snes_load_pkg::mem_mask_t'(1024) << ram_size_code) -
                         snes_load_pkg::mem_mask_t'(1) : '0;

  // latched once per load, held while the core runs
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      rom_mask  <= '0;
      ram_mask  <= '0;
      sram_size <= '0;
    end else if (load_masks) begin
      rom_mask  <= rom_mask_next;
      ram_mask  <= ram_mask_next;
      sram_size <= ram_size_code;
    end
  end

endmodule

`default_nettype wire

/* logic/snes_load_pkg.sv */
`default_nettype none

package snes_load_pkg;

  // byte address widths on the cpu side
  localparam int fill_addr_bits = 17;
  localparam int wram_addr_bits = 17;
  localparam int aram_addr_bits = 16;

  // cycles between download end and mask latch
  localparam int settle_cycles = 6;
  // divider phase on which core reset may change
  localparam logic [1:0] div_release_phase = 2'd2;

  // header size code, size is 1 KiB << code
  typedef logic [3:0] size_code_t;
  // rom / cart ram address mask
  typedef logic [23:0] mem_mask_t;
  // clear sequence byte address, spans work ram
  typedef logic [fill_addr_bits-1:0] fill_addr_t;
  typedef logic [1:0] fill_mode_t;
  typedef logic [7:0] byte_t;
  typedef logic [15:0] word_t;

  // fill bytes
  localparam byte_t fill_byte_a = 8'h66;
  localparam byte_t fill_byte_b = 8'h99;
  localparam byte_t fill_byte_c = 8'h55;
  localparam byte_t fill_byte_ones = 8'hFF;
  localparam byte_t fill_byte_zero = 8'h00;

  // load sequencing states
  typedef enum logic [1:0] {
    ld_run,
    ld_download,
    ld_settle
  } load_state_t;

endpackage

`default_nettype wire

/* logic/snes_load_top.sv */
`default_nettype none

module snes_load_top (
  input  wire                                          clk_sys,
  input  wire                                          reset,
  input  wire                                          cart_download,
  input  wire                                          reset_request,
  input  wire snes_load_pkg::size_code_t               rom_size_code,
  input  wire snes_load_pkg::size_code_t               ram_size_code,
  input  wire snes_load_pkg::fill_mode_t               wram_fill_mode,
  input  wire snes_load_pkg::fill_mode_t               aram_fill_mode,
  // work ram, cpu side
  input  wire [snes_load_pkg::wram_addr_bits-1:0]      wram_addr,
  input  wire snes_load_pkg::byte_t                    wram_d,
  output wire snes_load_pkg::byte_t                    wram_q,
  input  wire                                          wram_ce_n,
  input  wire                                          wram_oe_n,
  input  wire                                          wram_we_n,
  // work ram, memory side
  output wire [snes_load_pkg::wram_addr_bits-2:0]      wram_mem_addr,
  output wire snes_load_pkg::word_t                    wram_mem_din,
  input  wire snes_load_pkg::word_t                    wram_mem_dout,
  output wire                                          wram_mem_we,
  output wire                                          wram_mem_be_hi,
  output wire                                          wram_mem_be_lo,
  output wire                                          wram_mem_re,
  // audio ram, cpu side
  input  wire [snes_load_pkg::aram_addr_bits-1:0]      aram_addr,
  input  wire snes_load_pkg::byte_t                    aram_d,
  output wire snes_load_pkg::byte_t                    aram_q,
  input  wire                                          aram_ce_n,
  input  wire                                          aram_oe_n,
  input  wire                                          aram_we_n,
  // audio ram, memory side
  output wire [snes_load_pkg::aram_addr_bits-2:0]      aram_mem_addr,
  output wire snes_load_pkg::word_t                    aram_mem_din,
  input  wire snes_load_pkg::word_t                    aram_mem_dout,
  output wire                                          aram_mem_we,
  output wire                                          aram_mem_be_hi,
  output wire                                          aram_mem_be_lo,
  output wire                                          aram_mem_re,
  // core side
  output wire snes_load_pkg::mem_mask_t                rom_mask,
  output wire snes_load_pkg::mem_mask_t                ram_mask,
  output wire snes_load_pkg::size_code_t               sram_size,
  output wire                                          core_reset_n,
  output wire                                          refresh,
  output wire                                          clearing
);

  wire                            div_tick;
  wire                            load_masks;
  wire                            fill_last;
  wire snes_load_pkg::fill_addr_t fill_addr;
  wire snes_load_pkg::byte_t      wram_fill_byte;
  wire snes_load_pkg::byte_t      aram_fill_byte;

  // download / settle / reset sequencing
  load_control i_load_control (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .reset_request (reset_request),
    .fill_last     (fill_last),
    .clearing      (clearing),
    .div_tick      (div_tick),
    .load_masks    (load_masks),
    .core_reset_n  (core_reset_n),
    .refresh       (refresh)
  );

  // shared clear address for both rams
  fill_counter i_fill_counter (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .clearing  (clearing),
    .div_tick  (div_tick),
    .fill_addr (fill_addr),
    .fill_last (fill_last)
  );

  mask_builder i_mask_builder (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .load_masks    (load_masks),
    .rom_size_code (rom_size_code),
    .ram_size_code (ram_size_code),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size)
  );

  // independent patterns per ram
  fill_pattern wram_pattern (
    .fill_addr (fill_addr),
    .fill_mode (wram_fill_mode),
    .fill_byte (wram_fill_byte)
  );

  fill_pattern aram_pattern (
    .fill_addr (fill_addr),
    .fill_mode (aram_fill_mode),
    .fill_byte (aram_fill_byte)
  );

  byte_lane_bridge #(
    .addr_bits (snes_load_pkg::wram_addr_bits)
  ) wram_bridge (
    .clearing  (clearing),
    .fill_addr (fill_addr),
    .fill_byte (wram_fill_byte),
    .ram_addr  (wram_addr),
    .ram_d     (wram_d),
    .ram_ce_n  (wram_ce_n),
    .ram_oe_n  (wram_oe_n),
    .ram_we_n  (wram_we_n),
    .mem_dout  (wram_mem_dout),
    .ram_q     (wram_q),
    .mem_addr  (wram_mem_addr),
    .mem_din   (wram_mem_din),
    .mem_we    (wram_mem_we),
    .mem_be_hi (wram_mem_be_hi),
    .mem_be_lo (wram_mem_be_lo),
    .mem_re    (wram_mem_re)
  );

  // audio ram only sees the low 16 address bits of the clear
  byte_lane_bridge #(
    .addr_bits (snes_load_pkg::aram_addr_bits)
  ) aram_bridge (
    .clearing  (clearing),
    .fill_addr (fill_addr),
    .fill_byte (aram_fill_byte),
    .ram_addr  (aram_addr),
    .ram_d     (aram_d),
    .ram_ce_n  (aram_ce_n),
    .ram_oe_n  (aram_oe_n),
    .ram_we_n  (aram_we_n),
    .mem_dout  (aram_mem_dout),
    .ram_q     (aram_q),
    .mem_addr  (aram_mem_addr),
    .mem_din   (aram_mem_din),
    .mem_we    (aram_mem_we),
    .mem_be_hi (aram_mem_be_hi),
    .mem_be_lo (aram_mem_be_lo),
    .mem_re    (aram_mem_re)
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+verification
logic/snes_load_pkg.sv
logic/load_control.sv
logic/fill_counter.sv
logic/fill_pattern.sv
logic/mask_builder.sv
logic/byte_lane_bridge.sv
logic/snes_load_top.sv
verification/tb_snes_load.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load sequencer testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_snes_load \
  -o sim_snes_load > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_snes_load > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

/* verification/tb_checks.svh */
`ifndef tb_checks_svh
`define tb_checks_svh

// running totals for the closing summary line
int checks = 0;
int errors = 0;

// cpu or fill byte
task automatic check_byte(input string what, input snes_load_pkg::byte_t got,
                          input snes_load_pkg::byte_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
  end
endtask

// memory word or word address
task automatic check_word(input string what, input snes_load_pkg::word_t got,
                          input snes_load_pkg::word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t: %s got %04h expected %04h", $time, what, got, exp);
  end
endtask

task automatic check_mask(input string what, input snes_load_pkg::mem_mask_t got,
                          input snes_load_pkg::mem_mask_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t: %s got %06h expected %06h", $time, what, got, exp);
  end
endtask

task automatic check_size(input string what, input snes_load_pkg::size_code_t got,
                          input snes_load_pkg::size_code_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

// strobes and flags
task automatic check_bit(input string what, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

`endif

/* verification/tb_snes_load.sv */
`default_nettype none

module tb_snes_load;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk_sys = 1'b0;
  logic reset;
  logic cart_download;
  logic reset_request;
  snes_load_pkg::size_code_t rom_size_code, ram_size_code, sram_size;
  snes_load_pkg::fill_mode_t wram_fill_mode, aram_fill_mode;
  snes_load_pkg::mem_mask_t rom_mask, ram_mask;
  logic core_reset_n, refresh, clearing;
  // work ram, both sides
  logic [snes_load_pkg::wram_addr_bits-1:0] wram_addr;
  logic [snes_load_pkg::wram_addr_bits-2:0] wram_mem_addr;
  snes_load_pkg::byte_t wram_d, wram_q;
  snes_load_pkg::word_t wram_mem_din, wram_mem_dout;
  logic wram_ce_n, wram_oe_n, wram_we_n;
  logic wram_mem_we, wram_mem_be_hi, wram_mem_be_lo, wram_mem_re;
  // audio ram, both sides
  logic [snes_load_pkg::aram_addr_bits-1:0] aram_addr;
  logic [snes_load_pkg::aram_addr_bits-2:0] aram_mem_addr;
  snes_load_pkg::byte_t aram_d, aram_q;
  snes_load_pkg::word_t aram_mem_din, aram_mem_dout;
  logic aram_ce_n, aram_oe_n, aram_we_n;
  logic aram_mem_we, aram_mem_be_hi, aram_mem_be_lo, aram_mem_re;

  // coverage maps, wram per byte and aram per word
  bit wram_seen [0:(1<<17)-1];
  bit aram_seen [0:(1<<15)-1];
  logic clearing_prev = 1'b0;
  logic [3:0] refresh_hist = '0;
  int refresh_samples = 0;
  int hold_run = 0;

  `include "tb_checks.svh"

  snes_load_top i_snes_load_top (.*);

  always #20 clk_sys = ~clk_sys;

  // expected clear byte for a byte address
  function automatic snes_load_pkg::byte_t fill_byte_of(input logic [16:0] a,
                                                        input snes_load_pkg::fill_mode_t m);
    case (m)
      2'd0: return (a[8] != a[2]) ? 8'h66 : 8'h99;
      2'd1: return (a[9] != a[0]) ? 8'hFF : 8'h00;
      2'd2: return 8'h55;
      default: return 8'hFF;
    endcase
  endfunction

  // low 10 + code bits set, nothing for an empty cart ram
  function automatic snes_load_pkg::mem_mask_t mask_of_code(
      input snes_load_pkg::size_code_t code, input bit empty_on_zero);
    snes_load_pkg::mem_mask_t m;
    m = '0;
    for (int i = 0; i < 24; i++) begin
      if (i < 10 + int'(code) && !(empty_on_zero && code == 4'd0)) begin
        m[i] = 1'b1;
      end
    end
    return m;
  endfunction

  // byte moved into its lane
  function automatic snes_load_pkg::word_t pack_lane(input snes_load_pkg::byte_t b, input logic hi);
    return snes_load_pkg::word_t'(b) << (hi ? 8 : 0);
  endfunction

  // byte taken back out of its lane
  function automatic snes_load_pkg::byte_t lane_byte(input snes_load_pkg::word_t w,
                                                     input logic hi);
    return snes_load_pkg::byte_t'(w >> (hi ? 8 : 0));
  endfunction

  // one bridge against the lane and strobe rules
  task automatic compare_bridge(input string name, input logic [16:0] cpu_addr,
                                input snes_load_pkg::byte_t d, input logic ce_n, oe_n, we_n,
                                input logic [15:0] maddr, input snes_load_pkg::word_t din,
                                input logic we, be_hi, be_lo, re,
                                input snes_load_pkg::word_t dout, input snes_load_pkg::byte_t q,
                                input snes_load_pkg::fill_mode_t mode);
    logic [16:0] fill_byte_addr;
    // byte address rebuilt from word address and lane
    fill_byte_addr = {maddr, be_hi};
    check_bit({name, " lane enables"}, be_lo, ~be_hi);
    if (clearing) begin
      check_bit({name, " clear we"}, we, 1'b1);
      check_bit({name, " clear re"}, re, 1'b0);
      check_word({name, " clear data"}, din,
                 pack_lane(fill_byte_of(fill_byte_addr, mode), be_hi));
    end else begin
      check_word({name, " word addr"}, snes_load_pkg::word_t'(maddr), cpu_addr[16:1]);
      check_bit({name, " lane hi"}, be_hi, cpu_addr[0]);
      check_bit({name, " we"}, we, ~ce_n & ~we_n);
      check_bit({name, " re"}, re, ~ce_n & ~oe_n);
      if (!ce_n && !we_n) begin
        check_word({name, " write data"}, din, pack_lane(d, cpu_addr[0]));
      end
      check_byte({name, " read data"}, q, lane_byte(dout, cpu_addr[0]));
    end
  endtask

  // compare process, ports settled at the falling edge
  always @(negedge clk_sys) begin
    if (reset) begin
      compare_bridge("wram", wram_addr, wram_d, wram_ce_n, wram_oe_n, wram_we_n, wram_mem_addr,
                     wram_mem_din, wram_mem_we, wram_mem_be_hi, wram_mem_be_lo, wram_mem_re,
                     wram_mem_dout, wram_q, wram_fill_mode);
      compare_bridge("aram", {1'b0, aram_addr}, aram_d, aram_ce_n, aram_oe_n, aram_we_n,
                     {1'b0, aram_mem_addr}, aram_mem_din, aram_mem_we, aram_mem_be_hi,
                     aram_mem_be_lo, aram_mem_re, aram_mem_dout, aram_q, aram_fill_mode);
      // fresh maps at each clear start
      if (clearing && !clearing_prev) begin
        foreach (wram_seen[i]) wram_seen[i] = 1'b0;
        foreach (aram_seen[i]) aram_seen[i] = 1'b0;
      end
      if (clearing && wram_mem_we) begin
        wram_seen[{wram_mem_addr, wram_mem_be_hi}] = 1'b1;
      end
      if (clearing && aram_mem_we) begin
        aram_seen[aram_mem_addr] = 1'b1;
      end
      clearing_prev = clearing;
      // refresh slot once per four cycles
      refresh_hist = {refresh_hist[2:0], refresh};
      refresh_samples++;
      if (refresh_samples >= 4) begin
        check_bit("refresh one in four", $countones(refresh_hist) == 1, 1'b1);
      end
      // a full divider period of hold parks the core
      if (cart_download || reset_request || clearing) begin
        hold_run++;
      end else begin
        hold_run = 0;
      end
      if (hold_run > 4) begin
        check_bit("core reset held", core_reset_n, 1'b0);
      end
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s at %0t", what, $time);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin : stimulus
    int n;
    int base;
    int miss;
    logic [31:0] r;
    logic [31:0] dq;
    snes_load_pkg::mem_mask_t exp_rom, exp_ram, old_rom;
    r = $urandom(76);
    reset = 1'b0;
    cart_download = 1'b0;
    reset_request = 1'b0;
    rom_size_code = '0;
    ram_size_code = '0;
    wram_fill_mode = '0;
    aram_fill_mode = '0;
    wram_addr = '0;
    wram_d = '0;
    wram_mem_dout = '0;
    {wram_ce_n, wram_oe_n, wram_we_n} = 3'b111;
    aram_addr = '0;
    aram_d = '0;
    aram_mem_dout = '0;
    {aram_ce_n, aram_oe_n, aram_we_n} = 3'b111;

    // reset values, sampled inside the reset window
    repeat (7) @(posedge clk_sys);
    @(negedge clk_sys);
    base = errors;
    check_bit("reset clearing", clearing, 1'b0);
    check_bit("reset wram we", wram_mem_we, 1'b0);
    check_bit("reset wram re", wram_mem_re, 1'b0);
    check_bit("reset aram we", aram_mem_we, 1'b0);
    check_bit("reset aram re", aram_mem_re, 1'b0);
    check_mask("reset rom mask", rom_mask, '0);
    check_mask("reset ram mask", ram_mask, '0);
    check_size("reset sram size", sram_size, '0);
    check_bit("reset core_reset_n", core_reset_n, 1'b0);
    $display("test reset_state: %0d errors", errors - base);
    @(posedge clk_sys);
    #2;
    reset = 1'b1;

    // cpu traffic, parity walks through both lanes
    base = errors;
    for (int i = 0; i < 64; i++) begin
      @(posedge clk_sys);
      #2;
      r = $urandom();
      dq = $urandom();
      wram_addr = {r[15:0], i[1]};
      aram_addr = {r[30:16], i[2]};
      wram_d = dq[7:0];
      aram_d = dq[15:8];
      {wram_ce_n, wram_we_n, wram_oe_n} = {1'b0, i[0], ~i[0]};
      {aram_ce_n, aram_we_n, aram_oe_n} = {1'b0, ~i[0], i[0]};
      dq = $urandom();
      wram_mem_dout = dq[15:0];
      aram_mem_dout = dq[31:16];
    end
    @(posedge clk_sys);
    #2;
    {wram_ce_n, wram_oe_n, wram_we_n} = 3'b111;
    {aram_ce_n, aram_oe_n, aram_we_n} = 3'b111;
    $display("test cpu_pass_through: %0d errors", errors - base);

    // first load has no cart ram
    for (int pass = 0; pass < 2; pass++) begin
      @(posedge clk_sys);
      #2;
      wram_fill_mode = snes_load_pkg::fill_mode_t'($urandom_range(3, 0));
      aram_fill_mode = snes_load_pkg::fill_mode_t'($urandom_range(3, 0));
      if (pass == 0) begin
        rom_size_code = snes_load_pkg::size_code_t'($urandom_range(6, 0));
        ram_size_code = '0;
      end else begin
        rom_size_code = snes_load_pkg::size_code_t'($urandom_range(13, 7));
        ram_size_code = snes_load_pkg::size_code_t'($urandom_range(15, 1));
      end
      cart_download = 1'b1;
      base = errors;
      n = 0;
      while (clearing !== 1'b1) begin
        if (n == 3) report_timeout("clear start");
        @(negedge clk_sys);
        n++;
      end
      n = 0;
      while (clearing !== 1'b0) begin
        if (n == 600000) report_timeout("clear end");
        @(negedge clk_sys);
        n++;
      end
      miss = 0;
      foreach (wram_seen[i]) miss += wram_seen[i] ? 0 : 1;
      foreach (aram_seen[i]) miss += aram_seen[i] ? 0 : 1;
      check_bit("clear reached every address", miss == 0, 1'b1);
      $display("test clear_%0d: modes %0d/%0d, %0d errors", pass, wram_fill_mode,
               aram_fill_mode, errors - base);

      // external reset covers the gap before the settle count loads
      base = errors;
      exp_rom = mask_of_code(rom_size_code, 1'b0);
      exp_ram = mask_of_code(ram_size_code, 1'b1);
      old_rom = rom_mask;
      @(posedge clk_sys);
      #2;
      reset_request = 1'b1;
      cart_download = 1'b0;
      repeat (2) @(posedge clk_sys);
      #2;
      reset_request = 1'b0;
      // rom codes of the two loads never overlap so the rom mask always moves
      n = 0;
      while (rom_mask === old_rom) begin
        if (n == 20) report_timeout("mask load");
        check_bit("core reset during settle", core_reset_n, 1'b0);
        @(negedge clk_sys);
        n++;
      end
      check_mask("rom mask", rom_mask, exp_rom);
      check_mask("ram mask", ram_mask, exp_ram);
      check_size("sram size", sram_size, ram_size_code);
      $display("test mask_load_%0d: codes %0d/%0d, %0d errors", pass, rom_size_code,
               ram_size_code, errors - base);

      // release lands on the next divider release phase
      base = errors;
      n = 0;
      while (core_reset_n !== 1'b1) begin
        if (n == 4) report_timeout("core reset release");
        @(negedge clk_sys);
        n++;
      end
      $display("test core_release_%0d: %0d errors", pass, errors - base);
    end

    // external reset request alone parks the running core
    base = errors;
    @(posedge clk_sys);
    #2;
    reset_request = 1'b1;
    repeat (8) @(posedge clk_sys);
    #2;
    reset_request = 1'b0;
    n = 0;
    while (core_reset_n !== 1'b1) begin
      if (n == 8) report_timeout("core reset after request");
      @(negedge clk_sys);
      n++;
    end
    $display("test reset_request: %0d errors", errors - base);

    finish_run();
  end

endmodule

`default_nettype wire
